//--- hw/bt_hdr_pkg.sv
//////////////////////////////
// bluetooth packet header codec
// shared widths, polynomials and frame counts
//////////////////////////////
package bt_hdr_pkg;

  //////////////////////////////
  // frame geometry
  //////////////////////////////

  // header field, type/flow/arqn/seqn plus lt_addr
  localparam int HDR_BITS   = 10;
  // hec appended after the header
  localparam int HEC_BITS   = 8;
  // whole frame before fec
  localparam int FRAME_BITS = HDR_BITS + HEC_BITS;
  // rate 1/3 repetition, chips per bit
  localparam int FEC_REP    = 3;

  //////////////////////////////
  // word types
  //////////////////////////////

  typedef logic [HDR_BITS-1:0] hdr_t;
  // uap doubles as the hec seed
  typedef logic [7:0]          uap_t;
  typedef logic [HEC_BITS-1:0] hec_t;
  // CLK[6:1] for the whitening seed
  typedef logic [5:0]          wseed_t;
  // position in the 18 bit frame
  typedef logic [4:0]          bit_idx_t;

  //////////////////////////////
  // generator polynomials
  //////////////////////////////

  // D^8+D^7+D^5+D^2+D+1, taps below D^8
  localparam hec_t HEC_POLY   = 8'hA7;
  // D^7+D^4+1, feedback lands on bit 4
  localparam int   WHITEN_TAP = 4;

endpackage

//--- hw/hdr_bit_if.sv
`timescale 1ns/100ps
//////////////////////////////
// header bit stream between two pipeline stages
//////////////////////////////
interface hdr_bit_if;

  // one cycle, start of a frame
  logic                 frame_start;
  // one cycle, bit valid, no acknowledge
  logic                 bit_strobe;
  logic                 bit_data;
  // frame position 0..17, valid with the strobe
  bt_hdr_pkg::bit_idx_t bit_index;

  // producer side
  modport src (
    output frame_start,
    output bit_strobe,
    output bit_data,
    output bit_index
  );

  // consumer side
  modport snk (
    input frame_start,
    input bit_strobe,
    input bit_data,
    input bit_index
  );

endinterface

//--- hw/hec_lfsr.sv
`timescale 1ns/100ps
//////////////////////////////
// HEC shift register
// code generator on transmit, remainder on receive
//////////////////////////////
module hec_lfsr (
  input  logic             clk_6M,
  input  logic             rstz,
  input  logic             load,
  input  bt_hdr_pkg::uap_t seed,
  input  logic             shift_in,
  input  logic             shift_out,
  input  logic             step,
  input  logic             din,
  output bt_hdr_pkg::hec_t rem
);

  // feedback, incoming bit against the msb
  logic             fb;
  // plain left shift, zero fill
  bt_hdr_pkg::hec_t shifted;

  assign fb      = din ^ rem[bt_hdr_pkg::HEC_BITS-1];
  assign shifted = {rem[bt_hdr_pkg::HEC_BITS-2:0], 1'b0};

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      rem <= '0;
    // seed with the uap at frame start
    else if (load)
      rem <= seed;
    // divide mode, header bits in
    else if (step && shift_in)
      rem <= fb ? (shifted ^ bt_hdr_pkg::HEC_POLY) : shifted;
    // read-out mode, msb carries the code bit
    else if (step && shift_out)
      rem <= shifted;
  end

endmodule

//--- hw/whiten_lfsr.sv
`timescale 1ns/100ps
//////////////////////////////
// whitening sequence, D^7+D^4+1
//////////////////////////////
module whiten_lfsr (
  input  logic               clk_6M,
  input  logic               rstz,
  input  logic               enable,
  input  logic               load,
  input  bt_hdr_pkg::wseed_t seed,
  input  logic               step,
  output logic               wbit
);

  // one extra stage above the clock field
  localparam int WLEN = $bits(bt_hdr_pkg::wseed_t) + 1;

  logic [WLEN-1:0] wreg;
  logic [WLEN-1:0] wnext;

  // rotate left, msb folded into the tap
  always_comb
  begin
    wnext                         = {wreg[WLEN-2:0], wreg[WLEN-1]};
    wnext[bt_hdr_pkg::WHITEN_TAP] = wreg[bt_hdr_pkg::WHITEN_TAP-1] ^ wreg[WLEN-1];
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      wreg <= '0;
    // disabled, all zero so the xor is transparent
    else if (!enable)
      wreg <= '0;
    // 1 followed by CLK[6:1]
    else if (load)
      wreg <= {1'b1, seed};
    else if (step)
      wreg <= wnext;
  end

  assign wbit = wreg[WLEN-1];

endmodule

//--- hw/hdr_tx_encode.sv
`timescale 1ns/100ps
//////////////////////////////
// transmit header serializer
// header lsb first, then hec, whitened
//////////////////////////////
module hdr_tx_encode (
  input  logic               clk_6M,
  input  logic               rstz,
  input  logic               chip_tick,
  input  logic               tx_start,
  input  bt_hdr_pkg::hdr_t   tx_header,
  input  bt_hdr_pkg::uap_t   tx_uap,
  input  bt_hdr_pkg::wseed_t clk_bits,
  input  logic               whiten_en,
  hdr_bit_if.src             out
);

  localparam bt_hdr_pkg::bit_idx_t LAST_IDX = bt_hdr_pkg::bit_idx_t'(bt_hdr_pkg::FRAME_BITS - 1);
  localparam bt_hdr_pkg::bit_idx_t HEC_IDX  = bt_hdr_pkg::bit_idx_t'(bt_hdr_pkg::HDR_BITS);
  localparam logic [1:0]           PH_LAST  = 2'(bt_hdr_pkg::FEC_REP - 1);

  logic                 active;
  // chip phase within the current bit
  logic [1:0]           phase;
  logic                 strobe;
  logic                 in_hdr;
  logic                 raw_bit;
  logic                 wbit;
  bt_hdr_pkg::bit_idx_t idx;
  bt_hdr_pkg::hdr_t     hdr_sr;
  bt_hdr_pkg::hec_t     hec_rem;

  //////////////////////////////
  // bit timing
  //////////////////////////////

  // new bit on phase 0 ticks only
  assign strobe = active && chip_tick && (phase == 2'd0);
  assign in_hdr = (idx < HEC_IDX);

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      active <= 1'b0;
      phase  <= 2'd0;
      idx    <= '0;
    end
    // start also restarts a running frame
    else if (tx_start)
    begin
      active <= 1'b1;
      phase  <= 2'd0;
      idx    <= '0;
    end
    else if (active && chip_tick)
    begin
      phase <= (phase == PH_LAST) ? 2'd0 : phase + 2'd1;
      if (strobe)
      begin
        idx <= idx + 5'd1;
        // done once bit 17 is out
        if (idx == LAST_IDX)
          active <= 1'b0;
      end
    end
  end

  // header shifter, lsb goes first
  always_ff @(posedge clk_6M)
  begin
    if (tx_start)
      hdr_sr <= tx_header;
    else if (strobe && in_hdr)
      hdr_sr <= hdr_sr >> 1;
  end

  //////////////////////////////
  // hec and whitening
  //////////////////////////////

  hec_lfsr u_hec (
    .clk_6M    (clk_6M),
    .rstz      (rstz),
    .load      (tx_start),
    .seed      (tx_uap),
    .shift_in  (in_hdr),
    .shift_out (!in_hdr),
    .step      (strobe),
    .din       (hdr_sr[0]),
    .rem       (hec_rem)
  );

  whiten_lfsr u_whiten (
    .clk_6M (clk_6M),
    .rstz   (rstz),
    .enable (whiten_en),
    .load   (tx_start),
    .seed   (clk_bits),
    .step   (strobe),
    .wbit   (wbit)
  );

  // header bit, or hec msb for bits 10..17
  assign raw_bit = in_hdr ? hdr_sr[0] : hec_rem[bt_hdr_pkg::HEC_BITS-1];

  assign out.frame_start = strobe && (idx == '0);
  assign out.bit_strobe  = strobe;
  assign out.bit_data    = raw_bit ^ wbit;
  assign out.bit_index   = idx;

endmodule

//--- hw/fec13_repeat.sv
`timescale 1ns/100ps
//////////////////////////////
// rate 1/3 fec, holds each bit three chips
//////////////////////////////
module fec13_repeat (
  input  logic   clk_6M,
  input  logic   rstz,
  input  logic   chip_tick,
  hdr_bit_if.snk in,
  output logic   tx_bit,
  output logic   tx_active
);

  localparam bt_hdr_pkg::bit_idx_t LAST_IDX = bt_hdr_pkg::bit_idx_t'(bt_hdr_pkg::FRAME_BITS - 1);
  // chips left after the strobe of a bit
  localparam logic [1:0]           CNT_LAST = 2'(bt_hdr_pkg::FEC_REP - 2);

  // bit 17 on the line
  logic       last_bit;
  logic [1:0] chip_cnt;
  logic       frame_end;

  // third chip of bit 17
  assign frame_end = last_bit && chip_tick && (chip_cnt == CNT_LAST);

  // line register, one clock behind the strobe
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      tx_bit <= 1'b0;
    else if (in.bit_strobe)
      tx_bit <= in.bit_data;
    else if (frame_end)
      tx_bit <= 1'b0;
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      tx_active <= 1'b0;
      last_bit  <= 1'b0;
      chip_cnt  <= 2'd0;
    end
    // rises with the first bit on the line
    else if (in.frame_start)
    begin
      tx_active <= 1'b1;
      last_bit  <= 1'b0;
      chip_cnt  <= 2'd0;
    end
    // strobe tick is chip 0 of bit 17
    else if (in.bit_strobe && (in.bit_index == LAST_IDX))
    begin
      last_bit <= 1'b1;
      chip_cnt <= 2'd0;
    end
    else if (frame_end)
    begin
      tx_active <= 1'b0;
      last_bit  <= 1'b0;
    end
    else if (last_bit && chip_tick)
      chip_cnt <= chip_cnt + 2'd1;
  end

endmodule

//--- hw/fec13_vote.sv
`timescale 1ns/100ps
//////////////////////////////
// rate 1/3 fec, 2 of 3 majority per bit
//////////////////////////////
module fec13_vote (
  input  logic   clk_6M,
  input  logic   rstz,
  input  logic   chip_tick,
  input  logic   rx_start,
  input  logic   rx_bit,
  hdr_bit_if.src out
);

  localparam bt_hdr_pkg::bit_idx_t LAST_IDX = bt_hdr_pkg::bit_idx_t'(bt_hdr_pkg::FRAME_BITS - 1);
  localparam logic [1:0]           CNT_LAST = 2'(bt_hdr_pkg::FEC_REP - 1);

  logic                 armed;
  logic [1:0]           chip_cnt;
  // first two chips of the triplet
  logic [1:0]           chips;
  logic                 third_chip;
  logic                 maj;
  logic                 fs_q;
  logic                 strobe_q;
  logic                 data_q;
  bt_hdr_pkg::bit_idx_t idx;
  bt_hdr_pkg::bit_idx_t index_q;

  assign third_chip = armed && !rx_start && chip_tick && (chip_cnt == CNT_LAST);
  // any two of three
  assign maj = (chips[0] & chips[1]) | (chips[0] & rx_bit) | (chips[1] & rx_bit);

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      armed    <= 1'b0;
      chip_cnt <= 2'd0;
      idx      <= '0;
      fs_q     <= 1'b0;
      strobe_q <= 1'b0;
    end
    else
    begin
      fs_q     <= rx_start;
      strobe_q <= third_chip;
      if (rx_start)
      begin
        armed    <= 1'b1;
        chip_cnt <= 2'd0;
        idx      <= '0;
      end
      else if (third_chip)
      begin
        chip_cnt <= 2'd0;
        idx      <= idx + 5'd1;
        // idle after bit 17 until the next start
        if (idx == LAST_IDX)
          armed <= 1'b0;
      end
      else if (armed && chip_tick)
        chip_cnt <= chip_cnt + 2'd1;
    end
  end

  // chip store and voted bit
  always_ff @(posedge clk_6M)
  begin
    if (armed && chip_tick && !third_chip)
      chips[chip_cnt[0]] <= rx_bit;
    if (third_chip)
    begin
      data_q  <= maj;
      index_q <= idx;
    end
  end

  assign out.frame_start = fs_q;
  assign out.bit_strobe  = strobe_q;
  assign out.bit_data    = data_q;
  assign out.bit_index   = index_q;

endmodule

//--- hw/hdr_rx_decode.sv
`timescale 1ns/100ps
//////////////////////////////
// receive header decode
// dewhiten, hec check, header collect
//////////////////////////////
module hdr_rx_decode (
  input  logic               clk_6M,
  input  logic               rstz,
  input  bt_hdr_pkg::uap_t   rx_uap,
  input  bt_hdr_pkg::wseed_t clk_bits,
  input  logic               whiten_en,
  hdr_bit_if.snk             in,
  output bt_hdr_pkg::hdr_t   rx_header,
  output logic               rx_hec_good,
  output logic               rx_done
);

  localparam bt_hdr_pkg::bit_idx_t LAST_IDX = bt_hdr_pkg::bit_idx_t'(bt_hdr_pkg::FRAME_BITS - 1);
  localparam bt_hdr_pkg::bit_idx_t HEC_IDX  = bt_hdr_pkg::bit_idx_t'(bt_hdr_pkg::HDR_BITS);

  logic             wbit;
  // dewhitened bit
  logic             dbit;
  logic             frame_end;
  logic             last_ok;
  bt_hdr_pkg::hec_t hec_rem;
  bt_hdr_pkg::hdr_t hdr_sr;

  assign dbit      = in.bit_data ^ wbit;
  assign frame_end = in.bit_strobe && (in.bit_index == LAST_IDX);

  //////////////////////////////
  // hec check and dewhitening
  //////////////////////////////

  // all 18 bits divided in, zero remainder means pass
  hec_lfsr u_hec (
    .clk_6M    (clk_6M),
    .rstz      (rstz),
    .load      (in.frame_start),
    .seed      (rx_uap),
    .shift_in  (1'b1),
    .shift_out (1'b0),
    .step      (in.bit_strobe),
    .din       (dbit),
    .rem       (hec_rem)
  );

  whiten_lfsr u_whiten (
    .clk_6M (clk_6M),
    .rstz   (rstz),
    .enable (whiten_en),
    .load   (in.frame_start),
    .seed   (clk_bits),
    .step   (in.bit_strobe),
    .wbit   (wbit)
  );

  // remainder after the last step, poly bit 0 is set
  // so zero needs a zero feedback and zero low bits
  assign last_ok = (hec_rem[bt_hdr_pkg::HEC_BITS-2:0] == '0) &&
                   !(dbit ^ hec_rem[bt_hdr_pkg::HEC_BITS-1]);

  //////////////////////////////
  // header collect and result
  //////////////////////////////

  // lsb arrives first, shift in from the top
  always_ff @(posedge clk_6M)
  begin
    if (in.bit_strobe && (in.bit_index < HEC_IDX))
      hdr_sr <= {dbit, hdr_sr[bt_hdr_pkg::HDR_BITS-1:1]};
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      rx_done     <= 1'b0;
      rx_header   <= '0;
      rx_hec_good <= 1'b0;
    end
    else
    begin
      rx_done <= frame_end;
      // results held until the next frame end
      if (frame_end)
      begin
        rx_header   <= hdr_sr;
        rx_hec_good <= last_ok;
      end
    end
  end

endmodule

//--- hw/hdr_proc_top.sv
`timescale 1ns/100ps
//////////////////////////////
// header codec top
// tx encode and repeat, rx vote and decode
//////////////////////////////
module hdr_proc_top (
  input  logic               clk_6M,
  input  logic               rstz,
  input  logic               chip_tick,
  input  logic               tx_start,
  input  bt_hdr_pkg::hdr_t   tx_header,
  input  bt_hdr_pkg::uap_t   tx_uap,
  input  logic               rx_start,
  input  bt_hdr_pkg::uap_t   rx_uap,
  input  logic               rx_bit,
  input  bt_hdr_pkg::wseed_t clk_bits,
  input  logic               whiten_en,
  output logic               tx_bit,
  output logic               tx_active,
  output bt_hdr_pkg::hdr_t   rx_header,
  output logic               rx_hec_good,
  output logic               rx_done
);

  // stage links
  hdr_bit_if tx_bits ();
  hdr_bit_if rx_bits ();

  //////////////////////////////
  // transmit path
  //////////////////////////////

  hdr_tx_encode u_tx_encode (
    .clk_6M    (clk_6M),
    .rstz      (rstz),
    .chip_tick (chip_tick),
    .tx_start  (tx_start),
    .tx_header (tx_header),
    .tx_uap    (tx_uap),
    .clk_bits  (clk_bits),
    .whiten_en (whiten_en),
    .out       (tx_bits.src)
  );

  fec13_repeat u_fec_repeat (
    .clk_6M    (clk_6M),
    .rstz      (rstz),
    .chip_tick (chip_tick),
    .in        (tx_bits.snk),
    .tx_bit    (tx_bit),
    .tx_active (tx_active)
  );

  //////////////////////////////
  // receive path
  //////////////////////////////

  fec13_vote u_fec_vote (
    .clk_6M    (clk_6M),
    .rstz      (rstz),
    .chip_tick (chip_tick),
    .rx_start  (rx_start),
    .rx_bit    (rx_bit),
    .out       (rx_bits.src)
  );

  hdr_rx_decode u_rx_decode (
    .clk_6M      (clk_6M),
    .rstz        (rstz),
    .rx_uap      (rx_uap),
    .clk_bits    (clk_bits),
    .whiten_en   (whiten_en),
    .in          (rx_bits.snk),
    .rx_header   (rx_header),
    .rx_hec_good (rx_hec_good),
    .rx_done     (rx_done)
  );

endmodule

//--- verif/hdr_proc_chk.sv
`timescale 1ns/100ps
//////////////////////////////
// protocol checks on the codec top ports
//////////////////////////////
module hdr_proc_chk (
  input logic clk_6M,
  input logic rstz,
  input logic tx_start,
  input logic tx_bit,
  input logic tx_active,
  input logic rx_done
);

  // assertion failures so far
  int fail_count = 0;

  // rx_done is a single cycle pulse
  done_pulse: assert property (@(posedge clk_6M) disable iff (!rstz)
    rx_done |=> !rx_done)
    else
    begin
      $error("rx_done held high for more than one cycle");
      fail_count++;
    end

  // line quiet outside a frame
  idle_line: assert property (@(posedge clk_6M) disable iff (!rstz)
    !tx_active |-> !tx_bit)
    else
    begin
      $error("tx_bit high while tx_active is low");
      fail_count++;
    end

  // no restart in the middle of a frame
  start_idle: assert property (@(posedge clk_6M) disable iff (!rstz)
    tx_start |-> !tx_active)
    else
    begin
      $error("tx_start arrived while tx_active was high");
      fail_count++;
    end

endmodule

bind hdr_proc_top hdr_proc_chk u_chk (
  .clk_6M    (clk_6M),
  .rstz      (rstz),
  .tx_start  (tx_start),
  .tx_bit    (tx_bit),
  .tx_active (tx_active),
  .rx_done   (rx_done)
);

//--- verif/tb_hdr_proc.sv
`timescale 1ns/100ps
//////////////////////////////
// header codec testbench
// file vectors, line looped back with chip flips
//////////////////////////////
module tb_hdr_proc;

  // 18 bits, three chips each
  localparam int    FRAME_CHIPS   = 54;
  // worst case 55 ticks at 6 clocks plus margin
  localparam int    FRAME_TIMEOUT = 800;
  localparam string TEST_FILE     = "verif/hdr_tests.txt";

  logic       clk_6M;
  logic       rstz;
  logic       chip_tick;
  logic       tx_start;
  logic [9:0] tx_header;
  logic [7:0] tx_uap;
  logic       rx_start;
  logic [7:0] rx_uap;
  logic       rx_bit;
  logic [5:0] clk_bits;
  logic       whiten_en;
  logic       tx_bit;
  logic       tx_active;
  logic [9:0] rx_header;
  logic       rx_hec_good;
  logic       rx_done;

  int errors;
  int checks;
  int tests;

  hdr_proc_top dut (
    .clk_6M      (clk_6M),
    .rstz        (rstz),
    .chip_tick   (chip_tick),
    .tx_start    (tx_start),
    .tx_header   (tx_header),
    .tx_uap      (tx_uap),
    .rx_start    (rx_start),
    .rx_uap      (rx_uap),
    .rx_bit      (rx_bit),
    .clk_bits    (clk_bits),
    .whiten_en   (whiten_en),
    .tx_bit      (tx_bit),
    .tx_active   (tx_active),
    .rx_header   (rx_header),
    .rx_hec_good (rx_hec_good),
    .rx_done     (rx_done)
  );

  // 20 ns clock
  initial
  begin
    clk_6M = 1'b0;
    forever #10 clk_6M = ~clk_6M;
  end

  //////////////////////////////
  // one frame, tx looped to rx
  //////////////////////////////

  task automatic run_frame(input int num, input logic [9:0] hdr, input logic [7:0] txu,
                           input logic [7:0] rxu, input logic [5:0] cbits,
                           input logic wen, input logic [53:0] mask,
                           input logic [9:0] exp_hdr, input logic exp_good);
    int         tick_n;
    int         gap;
    int         waited;
    int         active_ticks;
    int         errs_before;
    logic       done_seen;
    logic       line_q;
    logic [9:0] got_hdr;
    logic       got_good;
    begin
      errs_before  = errors;
      tick_n       = 0;
      gap          = 2;
      waited       = 0;
      active_ticks = 0;
      done_seen    = 1'b0;
      line_q       = 1'b0;
      got_hdr      = '0;
      got_good     = 1'b0;
      @(posedge clk_6M);
      tx_header <= hdr;
      tx_uap    <= txu;
      rx_uap    <= rxu;
      clk_bits  <= cbits;
      whiten_en <= wen;
      tx_start  <= 1'b1;
      @(posedge clk_6M);
      tx_start <= 1'b0;
      while (!done_seen && waited < FRAME_TIMEOUT)
      begin
        @(posedge clk_6M);
        waited++;
        // values seen here belong to the cycle just ended
        if (chip_tick && tx_active)
          active_ticks++;
        // line keeps its last chip once tx goes idle
        if (tx_active)
          line_q = tx_bit;
        if (rx_done)
        begin
          done_seen = 1'b1;
          got_hdr   = rx_header;
          got_good  = rx_hec_good;
        end
        // tick 0 starts rx, tick n samples chip n-1
        if (gap == 0 && tick_n <= FRAME_CHIPS)
        begin
          chip_tick <= 1'b1;
          rx_start  <= (tick_n == 0);
          if (tick_n > 0)
            rx_bit <= line_q ^ mask[tick_n-1];
          tick_n++;
          // 3 to 6 clocks between ticks
          gap = 2 + int'($urandom % 4);
        end
        else
        begin
          chip_tick <= 1'b0;
          rx_start  <= 1'b0;
          if (gap > 0)
            gap--;
        end
      end
      chip_tick <= 1'b0;
      rx_start  <= 1'b0;

      checks++;
      assert (done_seen)
      else
      begin
        $display("test %0d: rx_done never came within %0d clocks", num, FRAME_TIMEOUT);
        errors++;
      end
      if (done_seen)
      begin
        checks += 2;
        assert (got_hdr == exp_hdr)
        else
        begin
          $display("MISMATCH at %0t: test %0d rx_header %h, expected %h",
                   $time, num, got_hdr, exp_hdr);
          errors++;
        end
        assert (got_good == exp_good)
        else
        begin
          $display("MISMATCH at %0t: test %0d rx_hec_good %0b, expected %0b",
                   $time, num, got_good, exp_good);
          errors++;
        end
      end
      // tick 0 opens the frame one clock before tx_active rises
      checks += 2;
      assert (active_ticks == FRAME_CHIPS - 1)
      else
      begin
        $display("MISMATCH at %0t: test %0d tx_active over %0d ticks, expected %0d",
                 $time, num, active_ticks, FRAME_CHIPS - 1);
        errors++;
      end
      assert (!tx_active)
      else
      begin
        $display("MISMATCH at %0t: test %0d tx_active still high after the frame",
                 $time, num);
        errors++;
      end
      $display("test %0d %s: hdr %h uap %h/%h whiten %0b -> rx %h hec_good %0b", num,
               (errors == errs_before) ? "ok" : "FAILED", hdr, txu, rxu, wen,
               got_hdr, got_good);
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial
  begin
    int          fd;
    int          n;
    string       line;
    logic [11:0] f_hdr;
    logic [7:0]  f_txu;
    logic [7:0]  f_rxu;
    logic [7:0]  f_clk;
    logic [3:0]  f_wh;
    logic [55:0] f_mask;
    logic [11:0] f_exp;
    logic [3:0]  f_flag;
    errors = 0;
    checks = 0;
    tests  = 0;
    void'($urandom(32'hdbdfc342));
    rstz      <= 1'b0;
    chip_tick <= 1'b0;
    tx_start  <= 1'b0;
    tx_header <= '0;
    tx_uap    <= '0;
    rx_start  <= 1'b0;
    rx_uap    <= '0;
    rx_bit    <= 1'b0;
    clk_bits  <= '0;
    whiten_en <= 1'b0;
    repeat (3) @(posedge clk_6M);
    rstz <= 1'b1;
    @(posedge clk_6M);
    // idle outputs after reset
    checks++;
    assert (!tx_bit && !tx_active && !rx_done && !rx_hec_good)
    else
    begin
      $display("MISMATCH at %0t: outputs not idle after reset", $time);
      errors++;
    end

    fd = $fopen(TEST_FILE, "r");
    if (fd == 0)
    begin
      $display("could not open the vector file %s", TEST_FILE);
      errors++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        n = $fgets(line, fd);
        // skip blanks and # column notes
        if (n > 1 && line.getc(0) != "#")
        begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h", f_hdr, f_txu, f_rxu,
                      f_clk, f_wh, f_mask, f_exp, f_flag);
          if (n != 8)
          begin
            $display("vector line could not be read: %s", line);
            errors++;
          end
          else
          begin
            tests++;
            run_frame(tests, f_hdr[9:0], f_txu, f_rxu, f_clk[5:0], f_wh[0],
                      f_mask[53:0], f_exp[9:0], f_flag[0]);
          end
        end
      end
      $fclose(fd);
    end
    if (tests == 0)
      $display("no test vectors were run");

    repeat (4) @(posedge clk_6M);
    // protocol assertions in the bound checker
    if (dut.u_chk.fail_count != 0)
    begin
      $display("bound checker reported %0d assertion failures", dut.u_chk.fail_count);
      errors += dut.u_chk.fail_count;
    end
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0 && tests > 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

//--- verif/hdr_tests.txt
# header tx_uap rx_uap clk_bits whiten flip_mask(chip 0 = lsb) exp_header exp_hec_good
# all hex, flip mask covers 54 chips
2A5 47 47 15 1 00000000000000 2A5 1
2A5 47 47 15 0 00000000000000 2A5 1
2A5 47 47 00 1 00000000000000 2A5 1
2A5 47 47 2A 1 00000000000000 2A5 1
133 C3 C3 3F 1 09249249249249 133 1
133 C3 C3 3F 0 12492492492492 133 1
0F0 1E 1E 21 1 24924924924924 0F0 1
133 C3 C3 3F 1 00000000000600 13B 0
0F0 1E 1E 21 0 00000000000007 0F1 0
3FF 00 00 0C 1 00003000000000 3FF 0
1FF 5A 5B 07 1 00000000000000 1FF 0
000 00 00 3E 1 00000000000000 000 1
3FF FF FF 01 1 00000000000000 3FF 1

//--- vlog.f
hw/bt_hdr_pkg.sv
hw/hdr_bit_if.sv
hw/hec_lfsr.sv
hw/whiten_lfsr.sv
hw/hdr_tx_encode.sv
hw/fec13_repeat.sv
hw/fec13_vote.sv
hw/hdr_rx_decode.sv
hw/hdr_proc_top.sv
verif/hdr_proc_chk.sv
verif/tb_hdr_proc.sv

//--- Bender.yml
package:
  name: bt_hdr_proc

sources:
  - hw/bt_hdr_pkg.sv
  - hw/hdr_bit_if.sv
  - hw/hec_lfsr.sv
  - hw/whiten_lfsr.sv
  - hw/hdr_tx_encode.sv
  - hw/fec13_repeat.sv
  - hw/fec13_vote.sv
  - hw/hdr_rx_decode.sv
  - hw/hdr_proc_top.sv
  - target: test
    files:
      - verif/hdr_proc_chk.sv
      - verif/tb_hdr_proc.sv
